/* Bender.yml */
package:
  name: wb_subsystem

sources:
  - common/wb_pkg.sv
  - writeback/flags_wb.sv
  - writeback/operand_select_wb.sv
  - writeback/commit_ctrl_wb.sv
  - writeback/writeback.sv
  - hdl/gpr_file.sv
  - hdl/arch_state.sv
  - hdl/wb_subsystem.sv
  - target: simulation
    files:
      - verification/tb_wb_subsystem.sv

/* common/wb_pkg.sv */
`default_nettype none

package wb_pkg;

   localparam int NUM_GPR = 8;

   // reserved bit 1 always reads as one after reset
   localparam logic [31:0] FLAGS_RESET = 32'h0000_0002;

   typedef logic [2:0] gpr_idx_t;

   typedef enum logic [1:0] {
      SIZE_BYTE  = 2'b00,
      SIZE_WORD  = 2'b01,
      SIZE_DWORD = 2'b10
   } datasize_t;

   // x86 EFLAGS layout, unused positions kept as reserved
   typedef struct packed {
      logic [19:0] rsvd_31_12;
      logic        of;
      logic        rsvd_10;
      logic        int_en;
      logic        rsvd_8;
      logic        sf;
      logic        zf;
      logic        rsvd_5;
      logic        af;
      logic        rsvd_3;
      logic        pf;
      logic        rsvd_1;
      logic        cf;
   } flags_bits_t;

   typedef union packed {
      logic [31:0] raw;
      flags_bits_t bits;
   } flags_u;

   typedef struct packed {
      logic        ld_gpr1;
      logic        ld_gpr2;
      logic        ld_gpr3;
      gpr_idx_t    dr3;
      datasize_t   datasize;
      logic        ld_flags;
      logic        pop_flags;
      // bit 0 cf, 1 pf, 2 af, 3 zf, 4 sf, 5 of
      logic [5:0]  flags_affected;
      logic        ld_eip;
      logic        ld_cs;
      logic        save_neip;
      logic        push_flags;
      logic        is_jne;
      logic        is_jnbe;
      logic        is_cmovc;
      logic        is_cmps2;
      logic        repne;
      logic        is_halt;
      logic        dcache_write;
   } wb_ctrl_t;

   typedef struct packed {
      logic        v;
      wb_ctrl_t    ctrl;
      logic [31:0] result_a;
      logic [31:0] result_b;
      logic [31:0] result_c;
      flags_u      flags;
      logic [31:0] neip;
      logic [31:0] neip_not_taken;
      logic [15:0] ncs;
      logic [31:0] address;
      gpr_idx_t    dr1;
      gpr_idx_t    dr2;
   } wb_uop_t;

   typedef struct packed {
      logic        en;
      gpr_idx_t    idx;
      datasize_t   size;
      logic [31:0] data;
   } gpr_wr_t;

   typedef struct packed {
      logic gpr1;
      logic gpr2;
      logic gpr3;
      logic flags;
      logic eip;
      logic dcache_write;
   } dep_t;

endpackage

`default_nettype wire

/* hdl/arch_state.sv */
`timescale 1ns/100ps
`default_nettype none

module arch_state (
   input  logic        CLK,
   input  logic        rst_n,
   input  logic        ld_eip,
   input  logic [31:0] eip_next,
   input  logic        ld_cs,
   input  logic [15:0] cs_next,
   input  logic        set_halt,
   output logic [31:0] eip,
   output logic [15:0] cs,
   output logic        halted
);

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         eip <= '0;
      end else if (ld_eip) begin
         eip <= eip_next;
      end
   end

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         cs <= '0;
      end else if (ld_cs) begin
         cs <= cs_next;
      end
   end

   // sticky, only reset brings the core back
   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         halted <= 1'b0;
      end else if (set_halt) begin
         halted <= 1'b1;
      end
   end

endmodule

`default_nettype wire

/* hdl/gpr_file.sv */
`timescale 1ns/100ps
`default_nettype none

module gpr_file (
   input  logic             CLK,
   input  logic             rst_n,
   input  wb_pkg::gpr_wr_t  wr1,
   input  wb_pkg::gpr_wr_t  wr2,
   input  wb_pkg::gpr_wr_t  wr3,
   input  wb_pkg::gpr_idx_t rd_idx,
   output logic [31:0]      rd_data
);
   import wb_pkg::*;

   logic [31:0] regs   [NUM_GPR];
   logic [31:0] regs_d [NUM_GPR];

   // partial writes keep the upper bits of the old value
   function automatic logic [31:0] merge(input logic [31:0] old_val, input gpr_wr_t wr);
      logic [31:0] res;
      case (wr.size)
         SIZE_BYTE: res = {old_val[31:8], wr.data[7:0]};
         SIZE_WORD: res = {old_val[31:16], wr.data[15:0]};
         default:   res = wr.data;
      endcase
      return res;
   endfunction

   // applied in port order so later ports override earlier ones
   always_comb begin
      for (int i = 0; i < NUM_GPR; i++) begin
         regs_d[i] = regs[i];
         if (wr1.en && wr1.idx == gpr_idx_t'(i)) begin
            regs_d[i] = merge(regs_d[i], wr1);
         end
         if (wr2.en && wr2.idx == gpr_idx_t'(i)) begin
            regs_d[i] = merge(regs_d[i], wr2);
         end
         if (wr3.en && wr3.idx == gpr_idx_t'(i)) begin
            regs_d[i] = merge(regs_d[i], wr3);
         end
      end
   end

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < NUM_GPR; i++) begin
            regs[i] <= '0;
         end
      end else begin
         for (int i = 0; i < NUM_GPR; i++) begin
            regs[i] <= regs_d[i];
         end
      end
   end

   assign rd_data = regs[rd_idx];

endmodule

`default_nettype wire

/* hdl/wb_subsystem.sv */
`timescale 1ns/100ps
`default_nettype none

module wb_subsystem (
   input  logic             CLK,
   input  logic             rst_n,
   input  wb_pkg::wb_uop_t  uop,
   input  logic             write_ready,
   output logic             dcache_write,
   output logic [31:0]      dcache_address,
   output logic [31:0]      dcache_data,
   output logic             stall,
   output wb_pkg::dep_t     dep,
   output logic             halted,
   output logic [31:0]      flags_fwd,
   output logic [31:0]      count_fwd,
   input  wb_pkg::gpr_idx_t rd_idx,
   output logic [31:0]      rd_data,
   output logic [31:0]      eip,
   output logic [15:0]      cs,
   output logic [31:0]      flags
);
   import wb_pkg::*;

   gpr_wr_t     gpr_wr1;
   gpr_wr_t     gpr_wr2;
   gpr_wr_t     gpr_wr3;
   logic        ld_eip;
   logic [31:0] eip_next;
   logic        ld_cs;
   logic [15:0] cs_next;
   logic        set_halt;

   writeback u_writeback (
      .CLK            (CLK),
      .rst_n          (rst_n),
      .uop            (uop),
      .write_ready    (write_ready),
      .halted         (halted),
      .gpr_wr1        (gpr_wr1),
      .gpr_wr2        (gpr_wr2),
      .gpr_wr3        (gpr_wr3),
      .ld_eip         (ld_eip),
      .eip_next       (eip_next),
      .ld_cs          (ld_cs),
      .cs_next        (cs_next),
      .set_halt       (set_halt),
      .dcache_write   (dcache_write),
      .dcache_address (dcache_address),
      .dcache_data    (dcache_data),
      .stall          (stall),
      .dep            (dep),
      .flags_fwd      (flags_fwd),
      .count_fwd      (count_fwd),
      .flags          (flags)
   );

   gpr_file u_gpr_file (
      .CLK     (CLK),
      .rst_n   (rst_n),
      .wr1     (gpr_wr1),
      .wr2     (gpr_wr2),
      .wr3     (gpr_wr3),
      .rd_idx  (rd_idx),
      .rd_data (rd_data)
   );

   arch_state u_arch_state (
      .CLK      (CLK),
      .rst_n    (rst_n),
      .ld_eip   (ld_eip),
      .eip_next (eip_next),
      .ld_cs    (ld_cs),
      .cs_next  (cs_next),
      .set_halt (set_halt),
      .eip      (eip),
      .cs       (cs),
      .halted   (halted)
   );

endmodule

`default_nettype wire

/* verification/tb_wb_subsystem.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_wb_subsystem;
   import wb_pkg::*;

   localparam int NUM_UOPS    = 2000;
   localparam int NUM_AFTER   = 16;
   localparam int STALL_LIMIT = 64;
   localparam int HALT_LIMIT  = 16;

   logic        CLK;
   logic        rst_n;
   wb_uop_t     uop;
   logic        write_ready;
   gpr_idx_t    rd_idx;
   logic        dcache_write;
   logic [31:0] dcache_address;
   logic [31:0] dcache_data;
   logic        stall;
   dep_t        dep;
   logic        halted;
   logic [31:0] flags_fwd;
   logic [31:0] count_fwd;
   logic [31:0] rd_data;
   logic [31:0] eip;
   logic [15:0] cs;
   logic [31:0] flags;

   // reference architectural state
   logic [31:0] m_gpr  [NUM_GPR];
   logic [31:0] g_next [NUM_GPR];
   flags_u      m_flags;
   logic [31:0] m_eip;
   logic [15:0] m_cs;
   logic        m_halted;

   // expected same-cycle view of the current micro-op
   wb_ctrl_t    ctl;
   logic        exp_live;
   logic        exp_stall;
   logic        exp_commit;
   logic        exp_dcw;
   logic        take_nt;
   logic        mov_ok;
   flags_u      exp_final;
   logic [31:0] exp_data1;
   dep_t        exp_dep;
   logic [31:0] rng;

   wb_subsystem dut (
      .CLK            (CLK),
      .rst_n          (rst_n),
      .uop            (uop),
      .write_ready    (write_ready),
      .dcache_write   (dcache_write),
      .dcache_address (dcache_address),
      .dcache_data    (dcache_data),
      .stall          (stall),
      .dep            (dep),
      .halted         (halted),
      .flags_fwd      (flags_fwd),
      .count_fwd      (count_fwd),
      .rd_idx         (rd_idx),
      .rd_data        (rd_data),
      .eip            (eip),
      .cs             (cs),
      .flags          (flags)
   );

   always #4 CLK = ~CLK;

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_rand();
      rng = xorshift32(rng);
      return rng;
   endfunction

   function automatic logic [31:0] size_merge(input logic [31:0] old_val, input datasize_t size,
                                              input logic [31:0] val);
      case (size)
         SIZE_BYTE: return {old_val[31:8], val[7:0]};
         SIZE_WORD: return {old_val[31:16], val[15:0]};
         default:   return val;
      endcase
   endfunction

   // cf 0, pf 2, af 4, zf 6, sf 7, of 11
   function automatic flags_u masked_flags(input flags_u cur, input flags_u nf,
                                           input logic [5:0] m);
      logic [31:0] pos;
      flags_u      res;
      pos = {20'b0, m[5], 3'b0, m[4], m[3], 1'b0, m[2], 1'b0, m[1], 1'b0, m[0]};
      res.raw = (cur.raw & ~pos) | (nf.raw & pos);
      return res;
   endfunction

   function automatic wb_uop_t random_uop();
      wb_uop_t     u;
      logic [31:0] r;
      logic [31:0] s;
      r = next_rand();
      s = next_rand();
      u = '0;
      u.v                   = r[2:0] != 3'd0;
      u.ctrl.ld_gpr1        = r[3];
      u.ctrl.ld_gpr2        = r[4];
      u.ctrl.ld_gpr3        = r[5];
      u.ctrl.dr3            = r[8:6];
      u.ctrl.datasize       = (s[21:20] == 2'b11) ? SIZE_DWORD : datasize_t'(s[21:20]);
      u.ctrl.ld_flags       = r[9];
      u.ctrl.pop_flags      = &r[11:10];
      u.ctrl.flags_affected = r[17:12];
      u.ctrl.ld_eip         = r[18];
      u.ctrl.ld_cs          = &r[20:19];
      u.ctrl.save_neip      = &r[22:21];
      u.ctrl.push_flags     = &r[24:23];
      u.ctrl.is_jne         = &r[26:25];
      u.ctrl.is_jnbe        = &r[28:27];
      u.ctrl.is_cmovc       = &r[30:29];
      u.ctrl.is_cmps2       = r[31] & s[8];
      u.ctrl.repne          = s[9];
      u.ctrl.dcache_write   = &s[11:10];
      u.result_a            = next_rand();
      u.result_b            = next_rand();
      // ecx of zero now and then so repne runs out
      u.result_c            = (s[13:12] == 2'b00) ? 32'd0 : next_rand();
      u.flags.raw           = next_rand();
      u.neip                = next_rand();
      u.neip_not_taken      = next_rand();
      u.ncs                 = s[31:16];
      u.address             = next_rand();
      u.dr1                 = s[16:14];
      u.dr2                 = s[19:17];
      return u;
   endfunction

   task automatic fail_compare(input string name, input logic [31:0] act, input logic [31:0] exp);
      $display("Mismatch at %0.1f ns: %s actual %h expected %h", $realtime, name, act, exp);
      $display("TEST FAILED");
      $fatal(1, "%s differs from the reference model", name);
   endtask

   task automatic fail_timeout(input string what);
      $display("Timeout at %0.1f ns while waiting for %s", $realtime, what);
      $display("TEST FAILED");
      $fatal(1, "wait loop ran out of cycles");
   endtask

   task automatic check_value(input string name, input logic [31:0] act, input logic [31:0] exp);
      assert (act === exp) else fail_compare(name, act, exp);
   endtask

   // random cache ready level
   task automatic drive_ready();
      logic [31:0] r;
      r = next_rand();
      write_ready = r[0];
   endtask

   // whole register file read back between edges
   task automatic sweep_regs();
      for (int i = 0; i < NUM_GPR; i++) begin
         rd_idx = gpr_idx_t'(i);
         #0.2;
         check_value($sformatf("gpr[%0d]", i), rd_data, m_gpr[i]);
      end
   endtask

   task automatic run_uop(input wb_uop_t u);
      int cycles;
      cycles = 0;
      @(negedge CLK);
      uop = u;
      drive_ready();
      sweep_regs();
      // uop stays put until the cache takes the store
      while (stall) begin
         @(negedge CLK);
         drive_ready();
         sweep_regs();
         cycles++;
         if (cycles > STALL_LIMIT) begin
            fail_timeout("stall to drop");
         end
      end
   endtask

   always_comb begin
      ctl        = uop.ctrl;
      exp_live   = uop.v & ~m_halted;
      exp_stall  = exp_live & ctl.dcache_write & ~write_ready;
      exp_commit = exp_live & ~exp_stall;
      exp_dcw    = exp_live & ctl.dcache_write;
      if (ctl.pop_flags) begin
         exp_final.raw = uop.result_a;
      end else begin
         exp_final = masked_flags(m_flags, uop.flags, ctl.flags_affected);
      end
      take_nt = (ctl.is_jne & exp_final.bits.zf) |
                (ctl.is_jnbe & (exp_final.bits.cf | exp_final.bits.zf)) |
                (exp_live & ctl.is_cmps2 & ctl.repne &
                 (exp_final.bits.zf | (uop.result_c == 32'd0)));
      mov_ok = ~ctl.is_cmovc | exp_final.bits.cf;
      if (ctl.push_flags) begin
         exp_data1 = exp_final.raw;
      end else if (ctl.save_neip) begin
         exp_data1 = uop.neip;
      end else begin
         exp_data1 = uop.result_a;
      end
      exp_dep.gpr1         = exp_live & ctl.ld_gpr1;
      exp_dep.gpr2         = exp_live & ctl.ld_gpr2 & mov_ok;
      exp_dep.gpr3         = exp_live & ctl.ld_gpr3;
      exp_dep.flags        = exp_live & ctl.ld_flags;
      exp_dep.eip          = exp_live & ctl.ld_eip;
      exp_dep.dcache_write = exp_dcw;
   end

   always @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < NUM_GPR; i++) begin
            m_gpr[i] <= '0;
         end
         m_flags.raw <= 32'h0000_0002;
         m_eip       <= '0;
         m_cs        <= '0;
         m_halted    <= 1'b0;
      end else if (exp_commit) begin
         g_next = m_gpr;
         if (ctl.ld_gpr1) begin
            g_next[uop.dr1] = size_merge(g_next[uop.dr1], ctl.datasize, exp_data1);
         end
         if (ctl.ld_gpr2 && mov_ok) begin
            g_next[uop.dr2] = size_merge(g_next[uop.dr2], ctl.datasize, uop.result_b);
         end
         if (ctl.ld_gpr3) begin
            g_next[ctl.dr3] = uop.result_c;
         end
         m_gpr <= g_next;
         if (ctl.ld_flags) m_flags <= exp_final;
         if (ctl.ld_eip) m_eip <= take_nt ? uop.neip_not_taken : uop.neip;
         if (ctl.ld_cs) m_cs <= uop.ncs;
         if (ctl.is_halt) m_halted <= 1'b1;
      end
   end

   assert property (@(posedge CLK) disable iff (!rst_n) stall == exp_stall)
      else fail_compare("stall", $sampled(stall), $sampled(exp_stall));
   assert property (@(posedge CLK) disable iff (!rst_n) dcache_write == exp_dcw)
      else fail_compare("dcache_write", $sampled(dcache_write), $sampled(exp_dcw));
   assert property (@(posedge CLK) disable iff (!rst_n) exp_dcw |-> dcache_address == uop.address)
      else fail_compare("dcache_address", $sampled(dcache_address), $sampled(uop.address));
   assert property (@(posedge CLK) disable iff (!rst_n) exp_dcw |-> dcache_data == exp_data1)
      else fail_compare("dcache_data", $sampled(dcache_data), $sampled(exp_data1));
   assert property (@(posedge CLK) disable iff (!rst_n) dep == exp_dep)
      else fail_compare("dep", $sampled(dep), $sampled(exp_dep));
   assert property (@(posedge CLK) disable iff (!rst_n) flags_fwd == exp_final.raw)
      else fail_compare("flags_fwd", $sampled(flags_fwd), $sampled(exp_final.raw));
   assert property (@(posedge CLK) disable iff (!rst_n) count_fwd == uop.result_c)
      else fail_compare("count_fwd", $sampled(count_fwd), $sampled(uop.result_c));
   assert property (@(posedge CLK) disable iff (!rst_n) flags == m_flags.raw)
      else fail_compare("flags", $sampled(flags), $sampled(m_flags.raw));
   assert property (@(posedge CLK) disable iff (!rst_n) eip == m_eip)
      else fail_compare("eip", $sampled(eip), $sampled(m_eip));
   assert property (@(posedge CLK) disable iff (!rst_n) cs == m_cs)
      else fail_compare("cs", $sampled(cs), $sampled(m_cs));
   assert property (@(posedge CLK) disable iff (!rst_n) halted == m_halted)
      else fail_compare("halted", $sampled(halted), $sampled(m_halted));

   initial begin
      wb_uop_t hlt;
      wb_uop_t u;
      int      cycles;
      CLK         = 1'b0;
      rst_n       = 1'b0;
      uop         = '0;
      write_ready = 1'b0;
      rd_idx      = '0;
      rng         = 32'd4;
      repeat (4) @(posedge CLK);
      @(negedge CLK);
      rst_n = 1'b1;

      check_value("halted", halted, 32'd0);
      check_value("stall", stall, 32'd0);
      check_value("dcache_write", dcache_write, 32'd0);
      check_value("dep", dep, 32'd0);
      check_value("flags", flags, 32'h0000_0002);
      check_value("eip", eip, 32'd0);
      check_value("cs", cs, 32'd0);
      sweep_regs();

      for (int n = 0; n < NUM_UOPS; n++) begin
         run_uop(random_uop());
      end

      hlt             = '0;
      hlt.v           = 1'b1;
      hlt.ctrl.is_halt = 1'b1;
      run_uop(hlt);
      cycles = 0;
      while (!halted) begin
         @(negedge CLK);
         cycles++;
         if (cycles > HALT_LIMIT) begin
            fail_timeout("halted to rise");
         end
      end

      // halted core must ignore everything that follows
      for (int n = 0; n < NUM_AFTER; n++) begin
         u   = random_uop();
         u.v = 1'b1;
         run_uop(u);
      end
      @(negedge CLK);
      sweep_regs();
      check_value("halted", halted, 32'd1);

      $display("TEST OK");
      $finish;
   end

endmodule

`default_nettype wire

/* verilog.f */
common/wb_pkg.sv
writeback/flags_wb.sv
writeback/operand_select_wb.sv
writeback/commit_ctrl_wb.sv
writeback/writeback.sv
hdl/gpr_file.sv
hdl/arch_state.sv
hdl/wb_subsystem.sv
verification/tb_wb_subsystem.sv

/* writeback/commit_ctrl_wb.sv */
`timescale 1ns/100ps
`default_nettype none

module commit_ctrl_wb (
   input  wb_pkg::wb_uop_t uop,
   input  wb_pkg::flags_u  final_flags,
   input  logic            write_ready,
   input  logic            halted,
   output logic            use_not_taken,
   output logic            ld_gpr1,
   output logic            ld_gpr2,
   output logic            ld_gpr3,
   output logic            ld_flags,
   output logic            ld_eip,
   output logic            ld_cs,
   output logic            dcache_write,
   output logic            set_halt,
   output logic            stall,
   output logic            repne_terminate,
   output wb_pkg::dep_t    dep
);
   import wb_pkg::*;

   wb_ctrl_t ctrl;
   logic     live;
   logic     commit;
   logic     cf;
   logic     zf;
   logic     gpr2_req;

   assign ctrl = uop.ctrl;
   assign cf   = final_flags.bits.cf;
   assign zf   = final_flags.bits.zf;

   // nothing retires once the core is halted
   assign live = uop.v & ~halted;

   assign stall  = live & ctrl.dcache_write & ~write_ready;
   assign commit = live & ~stall;

   // jne falls through on zf, jnbe on cf or zf
   assign use_not_taken = (ctrl.is_jne & zf) | (ctrl.is_jnbe & (cf | zf));

   // repne cmps stops on a match or when ecx runs out
   assign repne_terminate = live & ctrl.is_cmps2 & ctrl.repne &
                            (zf | (uop.result_c == 32'd0));

   // cmovc only moves when carry is set
   assign gpr2_req = ctrl.ld_gpr2 & (~ctrl.is_cmovc | cf);

   assign ld_gpr1  = commit & ctrl.ld_gpr1;
   assign ld_gpr2  = commit & gpr2_req;
   assign ld_gpr3  = commit & ctrl.ld_gpr3;
   assign ld_flags = commit & ctrl.ld_flags;
   assign ld_eip   = commit & ctrl.ld_eip;
   assign ld_cs    = commit & ctrl.ld_cs;
   assign set_halt = commit & ctrl.is_halt;

   // store stays up while stalled so the cache can take it
   assign dcache_write = live & ctrl.dcache_write;

   // hazard view ignores the stall
   always_comb begin
      dep.gpr1         = live & ctrl.ld_gpr1;
      dep.gpr2         = live & gpr2_req;
      dep.gpr3         = live & ctrl.ld_gpr3;
      dep.flags        = live & ctrl.ld_flags;
      dep.eip          = live & ctrl.ld_eip;
      dep.dcache_write = live & ctrl.dcache_write;
   end

endmodule

`default_nettype wire

/* writeback/flags_wb.sv */
`timescale 1ns/100ps
`default_nettype none

module flags_wb (
   input  logic           CLK,
   input  logic           rst_n,
   input  logic           ld,
   input  logic           pop,
   input  logic [5:0]     mask,
   input  wb_pkg::flags_u new_flags,
   input  logic [31:0]    popped,
   output wb_pkg::flags_u final_flags,
   output logic [31:0]    flags
);
   import wb_pkg::*;

   flags_u flags_q;
   flags_u merged;

   // only the six arithmetic bits take part in the merge
   always_comb begin
      merged = flags_q;
      if (mask[0]) merged.bits.cf = new_flags.bits.cf;
      if (mask[1]) merged.bits.pf = new_flags.bits.pf;
      if (mask[2]) merged.bits.af = new_flags.bits.af;
      if (mask[3]) merged.bits.zf = new_flags.bits.zf;
      if (mask[4]) merged.bits.sf = new_flags.bits.sf;
      if (mask[5]) merged.bits.of = new_flags.bits.of;
   end

   // popf replaces the whole word
   assign final_flags.raw = pop ? popped : merged.raw;

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         flags_q.raw <= FLAGS_RESET;
      end else if (ld) begin
         flags_q <= final_flags;
      end
   end

   assign flags = flags_q.raw;

endmodule

`default_nettype wire

/* writeback/operand_select_wb.sv */
`timescale 1ns/100ps
`default_nettype none

module operand_select_wb (
   input  wb_pkg::wb_uop_t uop,
   input  logic            use_not_taken,
   input  logic [31:0]     final_flags,
   output logic [31:0]     data1,
   output logic [31:0]     eip_next,
   output logic [15:0]     cs_next,
   output logic [31:0]     count
);
   import wb_pkg::*;

   wb_ctrl_t ctrl;

   assign ctrl = uop.ctrl;

   // pushf beats call-style return address save
   always_comb begin
      if (ctrl.push_flags) begin
         data1 = final_flags;
      end else if (ctrl.save_neip) begin
         data1 = uop.neip;
      end else begin
         data1 = uop.result_a;
      end
   end

   // fall-through eip for untaken jcc
   always_comb begin
      if (use_not_taken) begin
         eip_next = uop.neip_not_taken;
      end else begin
         eip_next = uop.neip;
      end
   end

   assign cs_next = uop.ncs;

   // ecx after the string step
   assign count = uop.result_c;

endmodule

`default_nettype wire

/* writeback/writeback.sv */
`timescale 1ns/100ps
`default_nettype none

module writeback (
   input  logic             CLK,
   input  logic             rst_n,
   input  wb_pkg::wb_uop_t  uop,
   input  logic             write_ready,
   input  logic             halted,
   output wb_pkg::gpr_wr_t  gpr_wr1,
   output wb_pkg::gpr_wr_t  gpr_wr2,
   output wb_pkg::gpr_wr_t  gpr_wr3,
   output logic             ld_eip,
   output logic [31:0]      eip_next,
   output logic             ld_cs,
   output logic [15:0]      cs_next,
   output logic             set_halt,
   output logic             dcache_write,
   output logic [31:0]      dcache_address,
   output logic [31:0]      dcache_data,
   output logic             stall,
   output wb_pkg::dep_t     dep,
   output logic [31:0]      flags_fwd,
   output logic [31:0]      count_fwd,
   output logic [31:0]      flags
);
   import wb_pkg::*;

   logic [31:0] data1;
   logic [31:0] count;
   flags_u      final_flags;
   logic        use_not_taken;
   logic        repne_terminate;
   logic        ld_gpr1;
   logic        ld_gpr2;
   logic        ld_gpr3;
   logic        ld_flags;

   operand_select_wb u_operand_select_wb (
      .uop           (uop),
      // string loop exit takes the fall-through eip too
      .use_not_taken (use_not_taken | repne_terminate),
      .final_flags   (final_flags.raw),
      .data1         (data1),
      .eip_next      (eip_next),
      .cs_next       (cs_next),
      .count         (count)
   );

   commit_ctrl_wb u_commit_ctrl_wb (
      .uop             (uop),
      .final_flags     (final_flags),
      .write_ready     (write_ready),
      .halted          (halted),
      .use_not_taken   (use_not_taken),
      .ld_gpr1         (ld_gpr1),
      .ld_gpr2         (ld_gpr2),
      .ld_gpr3         (ld_gpr3),
      .ld_flags        (ld_flags),
      .ld_eip          (ld_eip),
      .ld_cs           (ld_cs),
      .dcache_write    (dcache_write),
      .set_halt        (set_halt),
      .stall           (stall),
      .repne_terminate (repne_terminate),
      .dep             (dep)
   );

   flags_wb u_flags_wb (
      .CLK         (CLK),
      .rst_n       (rst_n),
      .ld          (ld_flags),
      .pop         (uop.ctrl.pop_flags),
      .mask        (uop.ctrl.flags_affected),
      .new_flags   (uop.flags),
      .popped      (uop.result_a),
      .final_flags (final_flags),
      .flags       (flags)
   );

   // port 3 is always a full dword write
   assign gpr_wr1 = '{en: ld_gpr1, idx: uop.dr1, size: uop.ctrl.datasize, data: data1};
   assign gpr_wr2 = '{en: ld_gpr2, idx: uop.dr2, size: uop.ctrl.datasize, data: uop.result_b};
   assign gpr_wr3 = '{en: ld_gpr3, idx: uop.ctrl.dr3, size: SIZE_DWORD, data: uop.result_c};

   assign dcache_address = uop.address;
   assign dcache_data    = data1;

   assign flags_fwd = final_flags.raw;
   assign count_fwd = count;

endmodule

`default_nettype wire
